// ==== eth_cfg_pkg.sv ====
`default_nettype none

package eth_cfg_pkg;

  localparam int IP_WIDTH          = 32;
  localparam int PORT_WIDTH        = 16;
  localparam int COUNT_WIDTH       = 32;
  localparam int REG_ADDR_WIDTH    = 8;
  localparam int REG_DATA_WIDTH    = 32;
  localparam int REG_STRB_WIDTH    = REG_DATA_WIDTH / 8;
  localparam int XAUI_STATUS_WIDTH = 8;

  typedef logic [IP_WIDTH-1:0]       ip_addr_t;
  typedef logic [PORT_WIDTH-1:0]     udp_port_t;
  typedef logic [COUNT_WIDTH-1:0]    frame_count_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [REG_STRB_WIDTH-1:0] reg_strb_t;
  typedef logic [1:0]                axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Register map, byte offsets
  localparam reg_addr_t REG_CTRL       = 8'h00;
  localparam reg_addr_t REG_LOCAL_IP   = 8'h04;
  localparam reg_addr_t REG_LOCAL_PORT = 8'h08;
  localparam reg_addr_t REG_MC_IP      = 8'h0C;
  localparam reg_addr_t REG_MC_MASK    = 8'h10;
  localparam reg_addr_t REG_STATUS     = 8'h14;
  localparam reg_addr_t REG_RX_GOOD    = 8'h18;
  localparam reg_addr_t REG_RX_DROP    = 8'h1C;

  localparam int CTRL_ENABLE_BIT     = 0;
  localparam int CTRL_SOFT_RESET_BIT = 1;

  localparam logic      RST_ENABLE     = 1'b0;
  localparam ip_addr_t  RST_LOCAL_IP   = '1;
  localparam udp_port_t RST_LOCAL_PORT = '1;
  localparam ip_addr_t  RST_MC_IP      = '1;
  localparam ip_addr_t  RST_MC_MASK    = '1;

  // Link is up when all lanes 6:2 of xaui_status are set
  localparam int LINK_UP_LSB   = 2;
  localparam int LINK_UP_LANES = 5;

endpackage

`default_nettype wire

// ==== eth_stream_pkg.sv ====
`default_nettype none

package eth_stream_pkg;

  import eth_cfg_pkg::*;

  localparam int RX_DATA_WIDTH = 64;

  typedef struct packed {
    logic [RX_DATA_WIDTH-1:0] data;
    logic                     valid;
    logic                     sof;
    logic                     eof;
    logic                     bad;
  } rx_word_t;

  // Valid on the sof beat
  typedef struct packed {
    ip_addr_t  dest_ip;
    udp_port_t dest_port;
    ip_addr_t  source_ip;
    udp_port_t source_port;
  } rx_header_t;

  typedef struct packed {
    logic      enable;
    ip_addr_t  local_ip;
    udp_port_t local_port;
    ip_addr_t  mc_ip;
    ip_addr_t  mc_mask;
  } net_cfg_t;

  typedef enum logic [1:0] {
    SWR_IDLE,
    SWR_HOLD,
    SWR_DONE
  } swr_state_t;

  localparam int SOFT_RESET_CYCLES = 8;
  localparam int SWR_CNT_WIDTH     = $clog2(SOFT_RESET_CYCLES);

  // Hardware would use 26
  localparam int LED_STRETCH_WIDTH = 6;

endpackage

`default_nettype wire

// ==== eth_cfg_regs.sv ====
`default_nettype none

module eth_cfg_regs
  import eth_cfg_pkg::*, eth_stream_pkg::*;
(
  input  wire logic                         clk,
  input  wire logic                         mac_resetRR,
  input  wire reg_addr_t                    s_axi_awaddr,
  input  wire logic                         s_axi_awvalid,
  output logic                              s_axi_awready,
  input  wire reg_data_t                    s_axi_wdata,
  input  wire reg_strb_t                    s_axi_wstrb,
  input  wire logic                         s_axi_wvalid,
  output logic                              s_axi_wready,
  output axi_resp_t                         s_axi_bresp,
  output logic                              s_axi_bvalid,
  input  wire logic                         s_axi_bready,
  input  wire reg_addr_t                    s_axi_araddr,
  input  wire logic                         s_axi_arvalid,
  output logic                              s_axi_arready,
  output reg_data_t                         s_axi_rdata,
  output axi_resp_t                         s_axi_rresp,
  output logic                              s_axi_rvalid,
  input  wire logic                         s_axi_rready,
  input  wire logic [XAUI_STATUS_WIDTH-1:0] xaui_status,
  input  wire frame_count_t                 good_count,
  input  wire frame_count_t                 drop_count,
  input  wire logic                         soft_reset_done,
  output net_cfg_t                          cfg,
  output logic                              soft_reset_req,
  output logic                              link_down
);

  logic                         wr_start;
  logic                         rd_start;
  reg_data_t                    ctrl_merged;
  reg_data_t                    port_merged;
  reg_data_t                    rd_mux;
  logic [XAUI_STATUS_WIDTH-1:0] xaui_q;
  logic                         link_up_q;

  function automatic reg_data_t merge_bytes(reg_data_t old_val, reg_data_t new_val,
                                            reg_strb_t strb);
    reg_data_t merged;
    merged = old_val;
    for (int i = 0; i < REG_STRB_WIDTH; i++) begin
      if (strb[i]) begin
        merged[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign wr_start = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
  assign rd_start = s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;

  assign s_axi_bresp = AXI_RESP_OKAY;
  assign s_axi_rresp = AXI_RESP_OKAY;

  always_comb begin
    ctrl_merged = merge_bytes({{(REG_DATA_WIDTH-2){1'b0}}, soft_reset_req, cfg.enable},
                              s_axi_wdata, s_axi_wstrb);
    port_merged = merge_bytes({{(REG_DATA_WIDTH-PORT_WIDTH){1'b0}}, cfg.local_port},
                              s_axi_wdata, s_axi_wstrb);
  end

  // Write channel and configuration registers
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      s_axi_awready    <= 1'b0;
      s_axi_wready     <= 1'b0;
      s_axi_bvalid     <= 1'b0;
      cfg.enable       <= RST_ENABLE;
      cfg.local_ip     <= RST_LOCAL_IP;
      cfg.local_port   <= RST_LOCAL_PORT;
      cfg.mc_ip        <= RST_MC_IP;
      cfg.mc_mask      <= RST_MC_MASK;
      soft_reset_req   <= 1'b0;
    end else begin
      s_axi_awready <= wr_start;
      s_axi_wready  <= wr_start;
      if (s_axi_awready) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bvalid && s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
      if (wr_start) begin
        case (s_axi_awaddr)
          REG_CTRL: begin
            cfg.enable     <= ctrl_merged[CTRL_ENABLE_BIT];
            soft_reset_req <= ctrl_merged[CTRL_SOFT_RESET_BIT];
          end
          REG_LOCAL_IP:   cfg.local_ip   <= merge_bytes(cfg.local_ip, s_axi_wdata, s_axi_wstrb);
          REG_LOCAL_PORT: cfg.local_port <= port_merged[PORT_WIDTH-1:0];
          REG_MC_IP:      cfg.mc_ip      <= merge_bytes(cfg.mc_ip, s_axi_wdata, s_axi_wstrb);
          REG_MC_MASK:    cfg.mc_mask    <= merge_bytes(cfg.mc_mask, s_axi_wdata, s_axi_wstrb);
          default: ;
        endcase
      end
      // Sequencer finished, request bit self-clears
      if (soft_reset_done) begin
        soft_reset_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      xaui_q    <= '0;
      link_up_q <= 1'b0;
    end else begin
      xaui_q    <= xaui_status;
      link_up_q <= &xaui_status[LINK_UP_LSB +: LINK_UP_LANES];
    end
  end

  assign link_down = !link_up_q;

  always_comb begin
    case (s_axi_araddr)
      REG_CTRL:       rd_mux = {{(REG_DATA_WIDTH-2){1'b0}}, soft_reset_req, cfg.enable};
      REG_LOCAL_IP:   rd_mux = cfg.local_ip;
      REG_LOCAL_PORT: rd_mux = {{(REG_DATA_WIDTH-PORT_WIDTH){1'b0}}, cfg.local_port};
      REG_MC_IP:      rd_mux = cfg.mc_ip;
      REG_MC_MASK:    rd_mux = cfg.mc_mask;
      REG_STATUS: begin
        rd_mux = {{(REG_DATA_WIDTH-XAUI_STATUS_WIDTH-2){1'b0}}, soft_reset_req, link_up_q,
                  xaui_q};
      end
      REG_RX_GOOD:    rd_mux = good_count;
      REG_RX_DROP:    rd_mux = drop_count;
      default:        rd_mux = '0;
    endcase
  end

  // Read channel, address still held while arready is high
  always_ff @(posedge clk) begin
    if (s_axi_arready) begin
      s_axi_rdata <= rd_mux;
    end
    if (mac_resetRR) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_arready <= rd_start;
      if (s_axi_arready) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rvalid && s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== eth_soft_reset_fsm.sv ====
`default_nettype none

module eth_soft_reset_fsm
  import eth_stream_pkg::*;
(
  input  wire logic clk,
  input  wire logic mac_resetRR,
  input  wire logic soft_reset_req,
  output logic      app_rst,
  output logic      soft_reset_done
);

  localparam logic [SWR_CNT_WIDTH-1:0] HOLD_LAST = SWR_CNT_WIDTH'(SOFT_RESET_CYCLES - 1);

  swr_state_t               state;
  swr_state_t               state_next;
  logic [SWR_CNT_WIDTH-1:0] hold_cnt;

  always_comb begin
    state_next = state;
    case (state)
      SWR_IDLE: begin
        if (soft_reset_req) begin
          state_next = SWR_HOLD;
        end
      end
      SWR_HOLD: begin
        if (hold_cnt == HOLD_LAST) begin
          state_next = SWR_DONE;
        end
      end
      SWR_DONE: state_next = SWR_IDLE;
      default:  state_next = SWR_IDLE;
    endcase
  end

  // System reset also holds the application in reset
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state    <= SWR_IDLE;
      hold_cnt <= '0;
      app_rst  <= 1'b1;
    end else begin
      state   <= state_next;
      app_rst <= (state_next == SWR_HOLD);
      if (state == SWR_HOLD) begin
        hold_cnt <= hold_cnt + 1'b1;
      end else begin
        hold_cnt <= '0;
      end
    end
  end

  assign soft_reset_done = (state == SWR_DONE);

endmodule

`default_nettype wire

// ==== eth_activity_timer.sv ====
`default_nettype none

module eth_activity_timer
  import eth_stream_pkg::*;
(
  input  wire logic clk,
  input  wire logic mac_resetRR,
  input  wire logic trigger,
  output logic      active
);

  logic [LED_STRETCH_WIDTH-1:0] stretch_cnt;

  // Counts down from all ones until the top bit falls
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      stretch_cnt <= '0;
    end else if (trigger) begin
      stretch_cnt <= '1;
    end else if (stretch_cnt[LED_STRETCH_WIDTH-1]) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  assign active = stretch_cnt[LED_STRETCH_WIDTH-1];

endmodule

`default_nettype wire

// ==== eth_rx_filter.sv ====
`default_nettype none

module eth_rx_filter
  import eth_cfg_pkg::*, eth_stream_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       app_rst,
  input  wire net_cfg_t   cfg,
  input  wire rx_word_t   rx_in,
  input  wire rx_header_t rx_in_header,
  output rx_word_t        rx_out,
  output rx_header_t      rx_out_header,
  output frame_count_t    good_count,
  output frame_count_t    drop_count,
  output logic            frame_accepted
);

  logic ip_hit;
  logic mc_hit;
  logic port_hit;
  logic sof_accept;
  logic beat_accept;
  logic accept_q;

  assign ip_hit   = (rx_in_header.dest_ip == cfg.local_ip);
  assign mc_hit   = ((rx_in_header.dest_ip & cfg.mc_mask) == (cfg.mc_ip & cfg.mc_mask));
  assign port_hit = (rx_in_header.dest_port == cfg.local_port);

  assign sof_accept  = cfg.enable && !rx_in.bad && port_hit && (ip_hit || mc_hit);
  // Decision taken on sof holds for the rest of the frame
  assign beat_accept = rx_in.sof ? sof_accept : accept_q;

  always_ff @(posedge clk) begin
    rx_out.data <= rx_in.data;
    rx_out.sof  <= rx_in.sof;
    rx_out.eof  <= rx_in.eof;
    rx_out.bad  <= rx_in.bad;
    if (rx_in.valid && rx_in.sof) begin
      rx_out_header <= rx_in_header;
    end
    if (app_rst) begin
      rx_out.valid   <= 1'b0;
      accept_q       <= 1'b0;
      good_count     <= '0;
      drop_count     <= '0;
      frame_accepted <= 1'b0;
    end else begin
      rx_out.valid   <= rx_in.valid && beat_accept;
      frame_accepted <= 1'b0;
      if (rx_in.valid && rx_in.sof) begin
        accept_q <= sof_accept;
      end
      if (rx_in.valid && rx_in.eof) begin
        // Bad on eof drops an accepted frame too
        if (beat_accept && !rx_in.bad) begin
          good_count     <= good_count + 1'b1;
          frame_accepted <= 1'b1;
        end else begin
          drop_count <= drop_count + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== eth_ctrl_top.sv ====
`default_nettype none

module eth_ctrl_top
  import eth_cfg_pkg::*, eth_stream_pkg::*;
(
  input  wire logic                         clk,
  input  wire logic                         mac_resetRR,
  input  wire reg_addr_t                    s_axi_awaddr,
  input  wire logic                         s_axi_awvalid,
  output logic                              s_axi_awready,
  input  wire reg_data_t                    s_axi_wdata,
  input  wire reg_strb_t                    s_axi_wstrb,
  input  wire logic                         s_axi_wvalid,
  output logic                              s_axi_wready,
  output axi_resp_t                         s_axi_bresp,
  output logic                              s_axi_bvalid,
  input  wire logic                         s_axi_bready,
  input  wire reg_addr_t                    s_axi_araddr,
  input  wire logic                         s_axi_arvalid,
  output logic                              s_axi_arready,
  output reg_data_t                         s_axi_rdata,
  output axi_resp_t                         s_axi_rresp,
  output logic                              s_axi_rvalid,
  input  wire logic                         s_axi_rready,
  input  wire logic [XAUI_STATUS_WIDTH-1:0] xaui_status,
  input  wire rx_word_t                     rx_in,
  input  wire rx_header_t                   rx_in_header,
  output rx_word_t                          rx_out,
  output rx_header_t                        rx_out_header,
  output logic                              led_up,
  output logic                              led_rx
);

  net_cfg_t     cfg;
  logic         soft_reset_req;
  logic         soft_reset_done;
  logic         app_rst;
  logic         link_down;
  logic         down_active;
  logic         frame_accepted;
  frame_count_t good_count;
  frame_count_t drop_count;

  eth_cfg_regs u_cfg_regs (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .s_axi_awaddr    (s_axi_awaddr),
    .s_axi_awvalid   (s_axi_awvalid),
    .s_axi_awready   (s_axi_awready),
    .s_axi_wdata     (s_axi_wdata),
    .s_axi_wstrb     (s_axi_wstrb),
    .s_axi_wvalid    (s_axi_wvalid),
    .s_axi_wready    (s_axi_wready),
    .s_axi_bresp     (s_axi_bresp),
    .s_axi_bvalid    (s_axi_bvalid),
    .s_axi_bready    (s_axi_bready),
    .s_axi_araddr    (s_axi_araddr),
    .s_axi_arvalid   (s_axi_arvalid),
    .s_axi_arready   (s_axi_arready),
    .s_axi_rdata     (s_axi_rdata),
    .s_axi_rresp     (s_axi_rresp),
    .s_axi_rvalid    (s_axi_rvalid),
    .s_axi_rready    (s_axi_rready),
    .xaui_status     (xaui_status),
    .good_count      (good_count),
    .drop_count      (drop_count),
    .soft_reset_done (soft_reset_done),
    .cfg             (cfg),
    .soft_reset_req  (soft_reset_req),
    .link_down       (link_down)
  );

  eth_soft_reset_fsm u_soft_reset (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .soft_reset_req  (soft_reset_req),
    .app_rst         (app_rst),
    .soft_reset_done (soft_reset_done)
  );

  eth_rx_filter u_rx_filter (
    .clk            (clk),
    .app_rst        (app_rst),
    .cfg            (cfg),
    .rx_in          (rx_in),
    .rx_in_header   (rx_in_header),
    .rx_out         (rx_out),
    .rx_out_header  (rx_out_header),
    .good_count     (good_count),
    .drop_count     (drop_count),
    .frame_accepted (frame_accepted)
  );

  // Link LED stretches the down condition
  eth_activity_timer u_link_timer (
    .clk         (clk),
    .mac_resetRR (mac_resetRR),
    .trigger     (link_down),
    .active      (down_active)
  );

  eth_activity_timer u_rx_timer (
    .clk         (clk),
    .mac_resetRR (mac_resetRR),
    .trigger     (frame_accepted),
    .active      (led_rx)
  );

  assign led_up = !down_active;

endmodule

`default_nettype wire

// ==== eth_ctrl_properties.sv ====
`default_nettype none

module eth_ctrl_properties
  import eth_stream_pkg::*;
(
  input wire logic     clk,
  input wire logic     mac_resetRR,
  input wire logic     s_axi_bvalid,
  input wire logic     s_axi_bready,
  input wire logic     s_axi_rvalid,
  input wire logic     s_axi_rready,
  input wire logic     soft_reset_req,
  input wire logic     app_rst,
  input wire rx_word_t rx_out
);

  int fail_count = 0;

  // Responses stay up until the manager takes them
  bvalid_held: assert property (@(posedge clk) disable iff (mac_resetRR)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
  else begin
    $error("bvalid dropped before bready");
    fail_count++;
  end

  rvalid_held: assert property (@(posedge clk) disable iff (mac_resetRR)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
  else begin
    $error("rvalid dropped before rready");
    fail_count++;
  end

  app_rst_length: assert property (@(posedge clk) disable iff (mac_resetRR)
    $rose(soft_reset_req) |=> app_rst [*SOFT_RESET_CYCLES] ##1 !app_rst)
  else begin
    $error("app_rst length differs from SOFT_RESET_CYCLES");
    fail_count++;
  end

  // No output beat in any cycle the application is held in reset
  no_output_in_reset: assert property (@(posedge clk) disable iff (mac_resetRR)
    app_rst |-> !rx_out.valid)
  else begin
    $error("rx_out valid while app_rst is high");
    fail_count++;
  end

endmodule

bind eth_ctrl_top eth_ctrl_properties u_properties (
  .clk            (clk),
  .mac_resetRR    (mac_resetRR),
  .s_axi_bvalid   (s_axi_bvalid),
  .s_axi_bready   (s_axi_bready),
  .s_axi_rvalid   (s_axi_rvalid),
  .s_axi_rready   (s_axi_rready),
  .soft_reset_req (soft_reset_req),
  .app_rst        (app_rst),
  .rx_out         (rx_out)
);

`default_nettype wire

// ==== tb_eth_ctrl.sv ====
`default_nettype none

module tb_eth_ctrl
  import eth_cfg_pkg::*, eth_stream_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int STRETCH         = 1 << (LED_STRETCH_WIDTH - 1);

  localparam logic [31:0] LOCAL_IP   = 32'h0A00_0002;
  localparam logic [15:0] LOCAL_PORT = 16'h1234;
  localparam logic [31:0] MC_IP      = 32'hEF01_0100;
  localparam logic [31:0] MC_MASK    = 32'hFFFF_FF00;

  typedef struct packed {
    rx_word_t    word;
    rx_header_t  hdr;
    logic [31:0] cycle;
  } exp_beat_t;

  logic                         clk;
  logic                         mac_resetRR;
  reg_addr_t                    s_axi_awaddr;
  logic                         s_axi_awvalid;
  logic                         s_axi_awready;
  reg_data_t                    s_axi_wdata;
  reg_strb_t                    s_axi_wstrb;
  logic                         s_axi_wvalid;
  logic                         s_axi_wready;
  axi_resp_t                    s_axi_bresp;
  logic                         s_axi_bvalid;
  logic                         s_axi_bready;
  reg_addr_t                    s_axi_araddr;
  logic                         s_axi_arvalid;
  logic                         s_axi_arready;
  reg_data_t                    s_axi_rdata;
  axi_resp_t                    s_axi_rresp;
  logic                         s_axi_rvalid;
  logic                         s_axi_rready;
  logic [XAUI_STATUS_WIDTH-1:0] xaui_status;
  rx_word_t                     rx_in;
  rx_header_t                   rx_in_header;
  rx_word_t                     rx_out;
  rx_header_t                   rx_out_header;
  logic                         led_up;
  logic                         led_rx;

  int          error_count;
  int          check_count;
  logic [31:0] rng_state;
  logic [31:0] cycle = '0;
  exp_beat_t   exp_q[$];
  logic        in_reset;

  // Reference model of the configuration and the frame counters
  logic         m_enable;
  ip_addr_t     m_local_ip;
  udp_port_t    m_local_port;
  ip_addr_t     m_mc_ip;
  ip_addr_t     m_mc_mask;
  frame_count_t exp_good;
  frame_count_t exp_drop;

  eth_ctrl_top u_eth_ctrl_top (
    .clk           (clk),
    .mac_resetRR   (mac_resetRR),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .xaui_status   (xaui_status),
    .rx_in         (rx_in),
    .rx_in_header  (rx_in_header),
    .rx_out        (rx_out),
    .rx_out_header (rx_out_header),
    .led_up        (led_up),
    .led_rx        (led_rx)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [31:0] apply_strobes(logic [31:0] old_val, logic [31:0] new_val,
                                                logic [3:0] strb);
    logic [31:0] byte_mask;
    byte_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~byte_mask) | (new_val & byte_mask);
  endfunction

  function automatic logic [31:0] expected_reg(reg_addr_t addr);
    case (addr)
      REG_CTRL:       return {31'b0, m_enable};
      REG_LOCAL_IP:   return m_local_ip;
      REG_LOCAL_PORT: return {16'b0, m_local_port};
      REG_MC_IP:      return m_mc_ip;
      REG_MC_MASK:    return m_mc_mask;
      REG_RX_GOOD:    return exp_good;
      REG_RX_DROP:    return exp_drop;
      default:        return 32'h0;
    endcase
  endfunction

  // Unicast or masked multicast IP, plus local port
  function automatic logic accepts(rx_header_t hdr, logic bad_on_sof);
    logic ip_ok;
    ip_ok = (hdr.dest_ip == m_local_ip) ||
            ((hdr.dest_ip & m_mc_mask) == (m_mc_ip & m_mc_mask));
    return m_enable && !bad_on_sof && (hdr.dest_port == m_local_port) && ip_ok;
  endfunction

  function automatic rx_header_t make_header(ip_addr_t ip, udp_port_t port);
    rx_header_t h;
    h.dest_ip     = ip;
    h.dest_port   = port;
    h.source_ip   = next_rand();
    h.source_port = udp_port_t'(next_rand());
    return h;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    check_count++;
    assert (cond === 1'b1) else begin
      $display("ERROR: %s", msg);
      error_count++;
    end
  endtask

  task automatic axi_write(input reg_addr_t addr, input logic [31:0] data,
                           input logic [3:0] strb);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!s_axi_awready);
    check_true(s_axi_wready, "wready did not rise together with awready");
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!s_axi_bvalid);
    check_value("s_axi_bresp", s_axi_bresp, 2'b00);
    // Response waits for bready
    @(posedge clk);
    #1;
    check_true(s_axi_bvalid, "bvalid dropped before bready was raised");
    s_axi_bready = 1'b1;
    @(posedge clk);
    #1;
    s_axi_bready = 1'b0;
    check_value("s_axi_bvalid", s_axi_bvalid, 1'b0);
  endtask

  task automatic axi_read(input reg_addr_t addr, output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!s_axi_arready);
    s_axi_arvalid = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!s_axi_rvalid);
    data = s_axi_rdata;
    check_value("s_axi_rresp", s_axi_rresp, 2'b00);
    // Data and valid hold until rready
    @(posedge clk);
    #1;
    check_true(s_axi_rvalid, "rvalid dropped before rready was raised");
    check_value("s_axi_rdata", s_axi_rdata, data);
    s_axi_rready = 1'b1;
    @(posedge clk);
    #1;
    s_axi_rready = 1'b0;
    check_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] merged;
    merged = apply_strobes(expected_reg(addr), data, strb);
    axi_write(addr, data, strb);
    case (addr)
      REG_CTRL:       m_enable     = merged[0];
      REG_LOCAL_IP:   m_local_ip   = merged;
      REG_LOCAL_PORT: m_local_port = merged[15:0];
      REG_MC_IP:      m_mc_ip      = merged;
      REG_MC_MASK:    m_mc_mask    = merged;
      default: ;
    endcase
  endtask

  task automatic check_reg(input reg_addr_t addr);
    logic [31:0] d;
    axi_read(addr, d);
    check_value($sformatf("reg 0x%02h", addr), d, expected_reg(addr));
  endtask

  task automatic check_counters();
    check_reg(REG_RX_GOOD);
    check_reg(REG_RX_DROP);
  endtask

  // Bad flag goes on the eof beat
  task automatic send_frame(input rx_header_t hdr, input int beats, input logic bad);
    rx_word_t  w;
    exp_beat_t e;
    logic      accept;
    accept = accepts(hdr, bad && (beats == 1));
    for (int i = 0; i < beats; i++) begin
      w.data[63:32] = next_rand();
      w.data[31:0]  = next_rand();
      w.valid       = 1'b1;
      w.sof         = (i == 0);
      w.eof         = (i == beats - 1);
      w.bad         = bad && (i == beats - 1);
      rx_in         = w;
      rx_in_header  = (i == 0) ? hdr : '0;
      if (accept && !in_reset) begin
        e.word  = w;
        e.hdr   = hdr;
        e.cycle = cycle + 1;
        exp_q.push_back(e);
      end
      @(posedge clk);
      #1;
    end
    rx_in        = '0;
    rx_in_header = '0;
    if (!in_reset) begin
      if (accept && !bad) begin
        exp_good++;
      end else begin
        exp_drop++;
      end
    end
  endtask

  task automatic wait_drained();
    repeat (4) @(posedge clk);
    #1;
    check_true(exp_q.size() == 0, "expected rx_out beats never appeared");
  endtask

  task automatic wait_led(input logic use_rx, input logic level, input int limit,
                          output int cycles);
    cycles = 0;
    while (((use_rx ? led_rx : led_up) !== level) && (cycles < limit)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  // Output beats must match the expected queue, one cycle after the input
  always @(negedge clk) begin
    exp_beat_t e;
    if (rx_out.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        check_true(1'b0, "rx_out valid for a beat that should have been dropped");
      end else begin
        e = exp_q.pop_front();
        check_value("rx_out.data", rx_out.data, e.word.data);
        check_value("rx_out sof/eof/bad", {rx_out.sof, rx_out.eof, rx_out.bad},
                    {e.word.sof, e.word.eof, e.word.bad});
        check_value("rx_out_header", rx_out_header, e.hdr);
        check_value("rx_out cycle", cycle, e.cycle);
      end
    end
  end

  task automatic test_register_access();
    reg_addr_t   cfg_addrs[4];
    logic [31:0] d;
    logic [3:0]  strb;
    cfg_addrs = '{REG_LOCAL_IP, REG_LOCAL_PORT, REG_MC_IP, REG_MC_MASK};
    check_reg(REG_CTRL);
    check_reg(REG_LOCAL_IP);
    check_reg(REG_LOCAL_PORT);
    check_reg(REG_MC_IP);
    check_reg(REG_MC_MASK);
    axi_read(REG_STATUS, d);
    check_value("reg status", d, 32'h0);
    check_counters();
    foreach (cfg_addrs[i]) begin
      d    = next_rand();
      strb = d[3:0];
      if (strb == 4'hF || strb == 4'h0) begin
        strb = 4'h6;
      end
      write_reg(cfg_addrs[i], next_rand(), strb);
      check_reg(cfg_addrs[i]);
    end
    write_reg(8'h24, next_rand(), 4'hF);
    check_reg(8'h24);
    check_reg(8'h20);
    check_reg(8'hFC);
  endtask

  task automatic test_unicast_filter();
    write_reg(REG_LOCAL_IP, LOCAL_IP, 4'hF);
    write_reg(REG_LOCAL_PORT, {16'h0, LOCAL_PORT}, 4'hF);
    write_reg(REG_MC_IP, MC_IP, 4'hF);
    write_reg(REG_MC_MASK, MC_MASK, 4'hF);
    write_reg(REG_CTRL, 32'h1, 4'h1);
    send_frame(make_header(LOCAL_IP, LOCAL_PORT), 4, 1'b0);
    send_frame(make_header(LOCAL_IP ^ 32'h1, LOCAL_PORT), 3, 1'b0);
    send_frame(make_header(LOCAL_IP, LOCAL_PORT + 16'h1), 2, 1'b0);
    write_reg(REG_CTRL, 32'h0, 4'h1);
    send_frame(make_header(LOCAL_IP, LOCAL_PORT), 3, 1'b0);
    write_reg(REG_CTRL, 32'h1, 4'h1);
    wait_drained();
    check_counters();
  endtask

  task automatic test_multicast_match();
    send_frame(make_header(MC_IP | 32'hAB, LOCAL_PORT), 3, 1'b0);
    send_frame(make_header(MC_IP | 32'h55, LOCAL_PORT), 2, 1'b0);
    // Bit 15 lies inside the mask
    send_frame(make_header(MC_IP ^ 32'h0000_8000, LOCAL_PORT), 2, 1'b0);
    wait_drained();
    check_counters();
  endtask

  task automatic test_bad_frame();
    send_frame(make_header(LOCAL_IP, LOCAL_PORT), 4, 1'b1);
    wait_drained();
    check_counters();
  endtask

  task automatic test_soft_reset();
    logic [31:0] d;
    int          polls;
    axi_write(REG_CTRL, 32'h3, 4'h1);
    in_reset = 1'b1;
    send_frame(make_header(LOCAL_IP, LOCAL_PORT), 3, 1'b0);
    in_reset = 1'b0;
    polls = 0;
    do begin
      axi_read(REG_STATUS, d);
      polls++;
    end while (d[9] && polls < 20);
    check_value("status busy", d[9], 1'b0);
    check_reg(REG_CTRL);
    exp_good = '0;
    exp_drop = '0;
    check_counters();
    wait_drained();
    send_frame(make_header(LOCAL_IP, LOCAL_PORT), 2, 1'b0);
    wait_drained();
    check_counters();
  endtask

  task automatic test_leds();
    logic [31:0] d;
    int          n;
    wait_led(1'b1, 1'b0, 4 * STRETCH, n);
    check_true(led_rx === 1'b0, "led_rx still lit before the test frame");
    send_frame(make_header(LOCAL_IP, LOCAL_PORT), 2, 1'b0);
    wait_led(1'b1, 1'b1, 8, n);
    check_true(led_rx === 1'b1, "led_rx did not light after an accepted frame");
    wait_led(1'b1, 1'b0, STRETCH + 8, n);
    check_true(led_rx === 1'b0 && n >= STRETCH - 2 && n <= STRETCH + 3,
               $sformatf("led_rx stayed lit %0d cycles, expected about %0d", n, STRETCH));
    wait_drained();
    check_value("led_up", led_up, 1'b0);
    xaui_status = 8'h7C;
    wait_led(1'b0, 1'b1, STRETCH + 8, n);
    check_true(led_up === 1'b1 && n >= STRETCH - 2 && n <= STRETCH + 3,
               $sformatf("led_up lit after %0d cycles, expected about %0d", n, STRETCH));
    axi_read(REG_STATUS, d);
    check_value("reg status", d, 32'h17C);
    xaui_status = 8'h3C;
    wait_led(1'b0, 1'b0, 6, n);
    check_true(led_up === 1'b0, "led_up did not go out after lane 6 dropped");
    wait_led(1'b0, 1'b1, STRETCH + 4, n);
    check_true(led_up === 1'b0, "led_up lit again while the link was down");
    axi_read(REG_STATUS, d);
    check_value("reg status", d, 32'h03C);
  endtask

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("ERROR: watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int prop_fails;
    clk           = 1'b0;
    mac_resetRR   = 1'b1;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    xaui_status   = '0;
    rx_in         = '0;
    rx_in_header  = '0;
    rng_state     = 32'd22279;
    error_count   = 0;
    check_count   = 0;
    in_reset      = 1'b0;
    m_enable      = 1'b0;
    m_local_ip    = 32'hFFFF_FFFF;
    m_local_port  = 16'hFFFF;
    m_mc_ip       = 32'hFFFF_FFFF;
    m_mc_mask     = 32'hFFFF_FFFF;
    exp_good      = '0;
    exp_drop      = '0;
    repeat (5) @(posedge clk);
    #1;
    mac_resetRR = 1'b0;
    test_register_access();
    test_unicast_filter();
    test_multicast_match();
    test_bad_frame();
    test_soft_reset();
    test_leds();
    prop_fails = u_eth_ctrl_top.u_properties.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, prop_fails);
    if (error_count == 0 && prop_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
eth_cfg_pkg.sv
eth_stream_pkg.sv
eth_cfg_regs.sv
eth_soft_reset_fsm.sv
eth_activity_timer.sv
eth_rx_filter.sv
eth_ctrl_top.sv
eth_ctrl_properties.sv
tb_eth_ctrl.sv
